//--- sources.f
+incdir+include
src/ipic_pkg.sv
src/ipic_ctrl_if.sv
src/ipic_prio_find.sv
src/ipic_line_detect.sv
src/ipic_regs.sv
src/ipic_pending.sv
src/ipic_service.sv
src/ipic_top.sv
dv/ipic_tb.sv

//--- Makefile
# Verilator build and run for the interrupt controller testbench

VERILATOR ?= verilator
TOP       ?= ipic_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HDRS := $(wildcard include/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, a header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Pass or fail comes from the log, not from the simulator exit code
run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "Test passed" $(LOG) || { echo "No pass line found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- include/ipic_tests.svh
// Directed tests for the interrupt controller, run from the testbench top
`ifndef IPIC_TESTS_SVH
`define IPIC_TESTS_SVH

// One-hot word for a line as IPR and ISVR show it
function automatic csr_data_t line_bit(input line_t line);
    return csr_data_t'(1) << line;
endfunction

// Select a line, then write enable, mode and inversion with IP kept 0
task automatic config_line(input line_t line, input bit ie, input bit im, input bit inv);
    csr_data_t icsr;
    icsr           = '0;
    icsr[ICSR_IE]  = ie;
    icsr[ICSR_IM]  = im;
    icsr[ICSR_INV] = inv;
    csr_write(ADDR_IDX, csr_data_t'(line));
    csr_write(ADDR_ICSR, icsr);
endtask

task automatic reset_values();
    csr_data_t rd;
    logic      req;
    start_test("reset_values");
    csr_read(ADDR_CISV, rd);
    if (rd !== csr_data_t'(IPIC_LINES)) mismatch("CISV", csr_data_t'(IPIC_LINES), rd);  // Void
    csr_read(ADDR_IPR, rd);
    if (rd !== '0) mismatch("IPR", '0, rd);
    csr_read(ADDR_ISVR, rd);
    if (rd !== '0) mismatch("ISVR", '0, rd);
    csr_read(ADDR_IDX, rd);
    if (rd !== '0) mismatch("IDX", '0, rd);
    sample_req(req);
    if (req !== 1'b0) mismatch("request", '0, csr_data_t'(req));
    finish_test();
endtask

// ------------------------------
// Detection modes
// ------------------------------
task automatic level_detect();
    csr_data_t rd;
    logic      req;
    start_test("level_detect");
    config_line(4'd3, 1'b1, 1'b0, 1'b0);
    set_pin(4'd3, 1'b1);
    wait_sync();
    csr_read(ADDR_IPR, rd);
    if (rd !== line_bit(4'd3)) mismatch("IPR after rise", line_bit(4'd3), rd);
    sample_req(req);
    if (req !== 1'b1) mismatch("request after rise", 32'd1, csr_data_t'(req));
    csr_write(ADDR_IPR, 32'h0000_ffff);                  // Blocked while the level is active
    sample_req(req);                                     // Bit must hold through the write edge
    if (req !== 1'b1) mismatch("request after clear", 32'd1, csr_data_t'(req));
    csr_read(ADDR_IPR, rd);
    if (rd !== line_bit(4'd3)) mismatch("IPR after clear", line_bit(4'd3), rd);
    set_pin(4'd3, 1'b0);
    wait_sync();
    csr_read(ADDR_IPR, rd);
    if (rd !== '0) mismatch("IPR after fall", '0, rd);
    sample_req(req);
    if (req !== 1'b0) mismatch("request after fall", '0, csr_data_t'(req));
    config_line(4'd3, 1'b0, 1'b0, 1'b0);
    finish_test();
endtask

task automatic inverted_edge();
    csr_data_t rd;
    logic      req;
    start_test("inverted_edge");
    config_line(4'd9, 1'b1, 1'b1, 1'b1);
    set_pin(4'd9, 1'b1);                                 // Idle high is inactive
    wait_sync();
    csr_read(ADDR_IPR, rd);
    if (rd !== '0) mismatch("IPR idle", '0, rd);
    set_pin(4'd9, 1'b0);                                 // Falling edge fires
    wait_sync();
    set_pin(4'd9, 1'b1);
    wait_sync();
    csr_read(ADDR_IPR, rd);
    if (rd !== line_bit(4'd9)) mismatch("IPR held", line_bit(4'd9), rd);
    sample_req(req);
    if (req !== 1'b1) mismatch("request", 32'd1, csr_data_t'(req));
    csr_write(ADDR_IPR, line_bit(4'd9));
    csr_read(ADDR_IPR, rd);
    if (rd !== '0) mismatch("IPR after clear", '0, rd);
    // Back to plain level mode with the pin low
    config_line(4'd9, 1'b0, 1'b0, 1'b0);
    set_pin(4'd9, 1'b0);
    wait_sync();
    csr_read(ADDR_IPR, rd);
    if (rd !== '0) mismatch("IPR after restore", '0, rd);
    finish_test();
endtask

// ------------------------------
// Service flow
// ------------------------------
task automatic nested_service();
    csr_data_t rd;
    logic      req;
    start_test("nested_service");
    config_line(4'd7, 1'b1, 1'b1, 1'b0);
    config_line(4'd2, 1'b1, 1'b1, 1'b0);
    set_pin(4'd7, 1'b1);
    wait_sync();
    csr_write(ADDR_SOI, '0);
    csr_read(ADDR_CISV, rd);
    if (rd !== 32'd7) mismatch("CISV first SOI", 32'd7, rd);
    csr_read(ADDR_ISVR, rd);
    if (rd !== line_bit(4'd7)) mismatch("ISVR first SOI", line_bit(4'd7), rd);
    csr_read(ADDR_IPR, rd);
    if (rd !== '0) mismatch("IPR first SOI", '0, rd);    // Edge bit consumed
    sample_req(req);
    if (req !== 1'b0) mismatch("request first SOI", '0, csr_data_t'(req));
    set_pin(4'd2, 1'b1);
    wait_sync();
    sample_req(req);                                     // Line 2 outranks line 7
    if (req !== 1'b1) mismatch("request preempt", 32'd1, csr_data_t'(req));
    csr_write(ADDR_SOI, '0);
    csr_read(ADDR_CISV, rd);
    if (rd !== 32'd2) mismatch("CISV nested SOI", 32'd2, rd);
    csr_read(ADDR_ISVR, rd);
    if (rd !== (line_bit(4'd2) | line_bit(4'd7)))
        mismatch("ISVR nested SOI", line_bit(4'd2) | line_bit(4'd7), rd);
    csr_write(ADDR_EOI, '0);
    csr_read(ADDR_CISV, rd);
    if (rd !== 32'd7) mismatch("CISV first EOI", 32'd7, rd);   // Resume outer line
    csr_write(ADDR_EOI, '0);
    csr_read(ADDR_CISV, rd);
    if (rd !== csr_data_t'(IPIC_LINES)) mismatch("CISV second EOI", csr_data_t'(IPIC_LINES), rd);
    csr_read(ADDR_ISVR, rd);
    if (rd !== '0) mismatch("ISVR second EOI", '0, rd);
    set_pin(4'd7, 1'b0);
    set_pin(4'd2, 1'b0);
    config_line(4'd7, 1'b0, 1'b0, 1'b0);
    config_line(4'd2, 1'b0, 1'b0, 1'b0);
    wait_sync();
    finish_test();
endtask

task automatic ignored_strobes();
    csr_data_t rd;
    start_test("ignored_strobes");
    csr_write(ADDR_SOI, '0);                             // Nothing pending
    csr_read(ADDR_CISV, rd);
    if (rd !== csr_data_t'(IPIC_LINES)) mismatch("CISV after SOI", csr_data_t'(IPIC_LINES), rd);
    csr_write(ADDR_EOI, '0);                             // Nothing in service
    csr_read(ADDR_CISV, rd);
    if (rd !== csr_data_t'(IPIC_LINES)) mismatch("CISV after EOI", csr_data_t'(IPIC_LINES), rd);
    csr_read(ADDR_ISVR, rd);
    if (rd !== '0) mismatch("ISVR", '0, rd);
    csr_read(ADDR_IPR, rd);
    if (rd !== '0) mismatch("IPR", '0, rd);
    finish_test();
endtask

task automatic icsr_readback();
    csr_data_t rd;
    csr_data_t exp;
    line_t     line;
    bit        ie;
    bit        im;
    bit        inv;
    start_test("icsr_readback");
    for (int n = 0; n < 8; n++) begin
        line = line_t'($urandom_range(IPIC_LINES - 1, 0));
        ie   = 1'($urandom_range(1, 0));
        im   = 1'($urandom_range(1, 0));
        inv  = 1'($urandom_range(1, 0));
        config_line(line, ie, im, inv);
        set_pin(line, inv);                              // Keeps the level inactive
        wait_sync();
        csr_read(ADDR_ICSR, rd);
        exp                     = '0;                    // IP and IS stay 0
        exp[ICSR_IE]            = ie;
        exp[ICSR_IM]            = im;
        exp[ICSR_INV]           = inv;
        exp[ICSR_PRV_LSB +: 2]  = 2'd3;                  // Machine level
        exp[ICSR_LN_LSB +: 4]   = line;
        if (rd !== exp) mismatch("ICSR", exp, rd);
    end
    finish_test();
endtask

`endif

//--- dv/ipic_tb.sv
// Testbench top for the interrupt controller with clock, reset, bus tasks and watchdog
`timescale 1ns/1ns

module ipic_tb import ipic_pkg::*; ();

    localparam int CLK_PERIOD  = 20;
    localparam int RST_CYCLES  = 16;
    localparam int SEED        = 61;
    localparam int NUM_TESTS   = 6;
    localparam int TEST_CYCLES = 400;                          // Budget per test
    localparam int TIMEOUT_NS  = NUM_TESTS * TEST_CYCLES * CLK_PERIOD;
    localparam int LN_W        = $clog2(IPIC_LINES);

    typedef logic [LN_W-1:0] line_t;                           // Line number

    logic                  clk;
    logic                  rst_n;
    logic [IPIC_LINES-1:0] irq_lines;
    logic                  csr_r_req;
    logic                  csr_w_req;
    csr_addr_t             csr_addr;
    csr_data_t             csr_wdata;
    csr_data_t             csr_rdata;
    logic                  irq_m_req;

    string cur_test;
    int    test_errs;                                          // Mismatches in running test
    int    err_total;
    int    tests_run;
    int    tests_failed;

    ipic_top #(.NUM_LINES(IPIC_LINES)) i_dut (
        .clk, .rst_n,
        .irq_lines_i (irq_lines),
        .csr_r_req_i (csr_r_req),
        .csr_w_req_i (csr_w_req),
        .csr_addr_i  (csr_addr),
        .csr_wdata_i (csr_wdata),
        .csr_rdata_o (csr_rdata),
        .irq_m_req_o (irq_m_req)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------
    // Bus and pin helpers
    // ------------------------------
    task automatic csr_write(input csr_addr_t addr, input csr_data_t data);
        @(posedge clk);
        csr_w_req <= 1'b1;
        csr_addr  <= addr;
        csr_wdata <= data;
        @(posedge clk);                                        // Register takes it here
        csr_w_req <= 1'b0;
    endtask

    task automatic csr_read(input csr_addr_t addr, output csr_data_t data);
        @(posedge clk);
        csr_r_req <= 1'b1;
        csr_addr  <= addr;
        @(negedge clk);
        data = csr_rdata;                                      // Settled mid-cycle
        @(posedge clk);
        csr_r_req <= 1'b0;
    endtask

    task automatic set_pin(input line_t line, input logic val);
        @(posedge clk);
        irq_lines[line] <= val;
    endtask

    // Two sync stages plus IPR, with a cycle to spare
    task automatic wait_sync();
        repeat (4) @(posedge clk);
    endtask

    task automatic sample_req(output logic req);
        @(negedge clk);
        req = irq_m_req;
    endtask

    task automatic mismatch(input string what, input csr_data_t exp, input csr_data_t act);
        $display("CHECK FAILED %s %s: expected 0x%08h, actual 0x%08h", cur_test, what, exp, act);
        test_errs++;
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        err_total += test_errs;
        if (test_errs != 0) tests_failed++;
        $display("%s finished with %0d mismatches", cur_test, test_errs);
    endtask

    `include "ipic_tests.svh"

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        int seed_val;
        seed_val  = $urandom(SEED);                            // One seed for the whole run
        rst_n     = 1'b0;
        irq_lines = '0;
        csr_r_req = 1'b0;
        csr_w_req = 1'b0;
        csr_addr  = '0;
        csr_wdata = '0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        reset_values();
        level_detect();
        inverted_edge();
        nested_service();
        ignored_strobes();
        icsr_readback();
        $display("Summary: %0d tests run, %0d failed, %0d mismatches",
                 tests_run, tests_failed, err_total);
        if (tests_failed == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog sized from test count and per-test budget
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Test failed");
        $finish;
    end

endmodule

//--- src/ipic_top.sv
// Interrupt controller top level joining line detect, registers, pending and service
`timescale 1ns/1ns

module ipic_top import ipic_pkg::*; #(
    parameter int NUM_LINES = IPIC_LINES
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [NUM_LINES-1:0] irq_lines_i,
    input  logic                 csr_r_req_i,
    input  logic                 csr_w_req_i,
    input  csr_addr_t            csr_addr_i,
    input  csr_data_t            csr_wdata_i,
    output csr_data_t            csr_rdata_o,
    output logic                 irq_m_req_o     // Level to the CSR side
);

    logic [NUM_LINES-1:0]       irq_lvl;
    logic [NUM_LINES-1:0]       irq_edge;
    logic [$clog2(NUM_LINES):0] cisv;

    ipic_ctrl_if #(.NUM_LINES(NUM_LINES)) ctrl ();

    ipic_line_detect #(.NUM_LINES(NUM_LINES)) u_detect (
        .clk, .rst_n, .irq_lines_i,
        .ctrl   (ctrl.detect),
        .lvl_o  (irq_lvl),
        .edge_o (irq_edge)
    );

    ipic_regs #(.NUM_LINES(NUM_LINES)) u_regs (
        .clk, .rst_n, .csr_r_req_i, .csr_w_req_i, .csr_addr_i, .csr_wdata_i, .csr_rdata_o,
        .cisv_i (cisv),
        .ctrl   (ctrl.regs)
    );

    ipic_pending #(.NUM_LINES(NUM_LINES)) u_pending (
        .clk, .rst_n,
        .lvl_i  (irq_lvl),
        .edge_i (irq_edge),
        .ctrl   (ctrl.pending)
    );

    ipic_service #(.NUM_LINES(NUM_LINES)) u_service (
        .clk, .rst_n,
        .ctrl        (ctrl.service),
        .cisv_o      (cisv),
        .irq_m_req_o (irq_m_req_o)
    );

endmodule

//--- src/ipic_service.sv
// Nested in-service tracking with SOI/EOI handling and the machine interrupt request
`timescale 1ns/1ns

module ipic_service #(
    parameter int NUM_LINES = 16
) (
    input  logic                       clk,
    input  logic                       rst_n,
    ipic_ctrl_if.service               ctrl,
    output logic [$clog2(NUM_LINES):0] cisv_o,
    output logic                       irq_m_req_o
);

    localparam int IDX_W = $clog2(NUM_LINES);
    localparam logic [IDX_W:0] VOID_VEC = (IDX_W+1)'(NUM_LINES);  // MSB set, nothing served

    logic [IDX_W:0]       cisv_q;
    logic [NUM_LINES-1:0] isvr_q;
    logic [NUM_LINES-1:0] isvr_rest;     // ISVR minus current line
    logic                 serv_vd;
    logic [IDX_W-1:0]     serv_idx;
    logic                 req_vd;
    logic [IDX_W-1:0]     req_idx;
    logic                 rest_vd;
    logic [IDX_W-1:0]     rest_idx;
    logic                 eoi;

    assign serv_vd  = ~cisv_q[IDX_W];
    assign serv_idx = cisv_q[IDX_W-1:0];

    // ------------------------------
    // Priority search
    // ------------------------------
    ipic_prio_find #(.WIDTH(NUM_LINES)) u_req_find (
        .vec_i   (ctrl.ipr & ctrl.ier),
        .found_o (req_vd),
        .idx_o   (req_idx)
    );

    always_comb begin
        isvr_rest = isvr_q;
        if (serv_vd) isvr_rest[serv_idx] = 1'b0;
    end

    // Outer line to return to after EOI
    ipic_prio_find #(.WIDTH(NUM_LINES)) u_rest_find (
        .vec_i   (isvr_rest),
        .found_o (rest_vd),
        .idx_o   (rest_idx)
    );

    // Only a strictly higher priority line may preempt
    assign irq_m_req_o = req_vd & (~serv_vd | (req_idx < serv_idx));

    assign ctrl.start     = ctrl.soi_wr & irq_m_req_o;   // SOI without request ignored
    assign ctrl.start_idx = req_idx;
    assign eoi            = ctrl.eoi_wr & serv_vd;        // EOI when idle ignored

    // ------------------------------
    // ISVR and CISV
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            isvr_q <= '0;
            cisv_q <= VOID_VEC;
        end else if (ctrl.start) begin
            isvr_q[req_idx] <= 1'b1;
            cisv_q          <= {1'b0, req_idx};
        end else if (eoi) begin
            isvr_q <= isvr_rest;
            cisv_q <= rest_vd ? {1'b0, rest_idx} : VOID_VEC;
        end
    end

    assign ctrl.isvr = isvr_q;
    assign cisv_o    = cisv_q;

    a_serv_in_isvr: assert property (@(posedge clk) disable iff (!rst_n)
        serv_vd |-> isvr_q[serv_idx]);

    // Started line must really be pending and enabled in the pending block
    a_start_req: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.start |-> (ctrl.ipr[ctrl.start_idx] && ctrl.ier[ctrl.start_idx]));

endmodule

//--- src/ipic_pending.sv
// Interrupt pending register with level follow, edge capture and clear rules
`timescale 1ns/1ns

module ipic_pending import ipic_pkg::*; #(
    parameter int NUM_LINES = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [NUM_LINES-1:0] lvl_i,
    input  logic [NUM_LINES-1:0] edge_i,
    ipic_ctrl_if.pending         ctrl
);

    logic [NUM_LINES-1:0] clr_req;   // Software or SOI asks to drop the bit
    logic [NUM_LINES-1:0] clr;       // Request that is allowed to act
    logic [NUM_LINES-1:0] ipr_d;
    logic [NUM_LINES-1:0] ipr_q;

    // Collect clear requests from all three sources
    always_comb begin
        clr_req = '0;
        if (ctrl.ipr_wr) begin
            clr_req = ctrl.wdata[NUM_LINES-1:0];       // Write 1 to clear
        end
        if (ctrl.icsr_wr && ctrl.wdata[ICSR_IP]) begin
            clr_req[ctrl.idx] = 1'b1;
        end
        if (ctrl.start) begin
            clr_req[ctrl.start_idx] = 1'b1;            // Accepted SOI consumes it
        end
    end

    // An active level would re-raise the bit at once, so it blocks the clear
    assign clr = clr_req & (ctrl.imr | ~lvl_i);

    always_comb begin
        for (int i = 0; i < NUM_LINES; i++) begin
            ipr_d[i] = clr[i]      ? 1'b0 :
                       ctrl.imr[i] ? (ipr_q[i] | edge_i[i]) :  // Edge sticks
                                     lvl_i[i];                 // Level follows
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) ipr_q <= '0;
        else        ipr_q <= ipr_d;
    end

    assign ctrl.ipr = ipr_q;

    // The front end only flags an edge on a line whose level is now active
    a_edge_on_lvl: assert property (@(posedge clk) disable iff (!rst_n)
        ((edge_i & ~lvl_i) == '0));

endmodule

//--- src/ipic_regs.sv
// CSR decoder and configuration registers of the interrupt controller, with read mux
`timescale 1ns/1ns

module ipic_regs import ipic_pkg::*; #(
    parameter int NUM_LINES = 16
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      csr_r_req_i,
    input  logic                      csr_w_req_i,
    input  csr_addr_t                 csr_addr_i,
    input  csr_data_t                 csr_wdata_i,
    output csr_data_t                 csr_rdata_o,
    input  logic [$clog2(NUM_LINES):0] cisv_i,     // Vector in service, MSB set means void
    ipic_ctrl_if.regs                 ctrl
);

    localparam int IDX_W = $clog2(NUM_LINES);

    logic                 idx_wr;
    logic [IDX_W-1:0]     idx_q;
    logic [NUM_LINES-1:0] ier_q;
    logic [NUM_LINES-1:0] imr_q;
    logic [NUM_LINES-1:0] iinvr_q;

    // ------------------------------
    // Write decode
    // ------------------------------
    always_comb begin
        ctrl.ipr_wr  = 1'b0;
        ctrl.eoi_wr  = 1'b0;
        ctrl.soi_wr  = 1'b0;
        ctrl.icsr_wr = 1'b0;
        idx_wr       = 1'b0;
        if (csr_w_req_i) begin
            case (csr_addr_i)
                ADDR_IPR:  ctrl.ipr_wr  = 1'b1;
                ADDR_EOI:  ctrl.eoi_wr  = 1'b1;
                ADDR_SOI:  ctrl.soi_wr  = 1'b1;
                ADDR_IDX:  idx_wr       = 1'b1;
                ADDR_ICSR: ctrl.icsr_wr = 1'b1;
                default: ;                       // CISV, CICSR, ISVR ignore writes
            endcase
        end
    end

    assign ctrl.wdata = csr_wdata_i;

    // ------------------------------
    // Index and per-line config
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx_q   <= '0;
            ier_q   <= '0;
            imr_q   <= '0;
            iinvr_q <= '0;
        end else begin
            if (idx_wr) begin
                idx_q <= csr_wdata_i[IDX_W-1:0];  // Upper bits dropped
            end
            if (ctrl.icsr_wr) begin
                ier_q[idx_q]   <= csr_wdata_i[ICSR_IE];
                imr_q[idx_q]   <= csr_wdata_i[ICSR_IM];
                iinvr_q[idx_q] <= csr_wdata_i[ICSR_INV];
            end
        end
    end

    assign ctrl.idx   = idx_q;
    assign ctrl.ier   = ier_q;
    assign ctrl.imr   = imr_q;
    assign ctrl.iinvr = iinvr_q;

    // ------------------------------
    // Read mux
    // ------------------------------
    always_comb begin
        csr_rdata_o = '0;
        if (csr_r_req_i) begin
            case (csr_addr_i)
                ADDR_CISV: csr_rdata_o = CSR_XLEN'(cisv_i);
                ADDR_IPR:  csr_rdata_o = CSR_XLEN'(ctrl.ipr);
                ADDR_ISVR: csr_rdata_o = CSR_XLEN'(ctrl.isvr);
                ADDR_IDX:  csr_rdata_o = CSR_XLEN'(idx_q);
                ADDR_ICSR: begin
                    csr_rdata_o[ICSR_IP]  = ctrl.ipr[idx_q];
                    csr_rdata_o[ICSR_IE]  = ier_q[idx_q];
                    csr_rdata_o[ICSR_IM]  = imr_q[idx_q];
                    csr_rdata_o[ICSR_INV] = iinvr_q[idx_q];
                    csr_rdata_o[ICSR_IS]  = ctrl.isvr[idx_q];
                    csr_rdata_o[ICSR_PRV_LSB +: $bits(prv_t)] = PRV_M;
                    csr_rdata_o[ICSR_LN_LSB +: ICSR_LN_W]     = ICSR_LN_W'(idx_q);
                end
                ADDR_CICSR, ADDR_EOI, ADDR_SOI: csr_rdata_o = '0;
                default: csr_rdata_o = '0;
            endcase
        end
    end

    // Decode above relies on a clean address whenever the CPU side strobes
    a_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
        (csr_r_req_i || csr_w_req_i) |-> !$isunknown(csr_addr_i));

endmodule

//--- src/ipic_line_detect.sv
// IRQ pin front end that synchronizes the lines and derives levels and edges
`timescale 1ns/1ns

module ipic_line_detect #(
    parameter int NUM_LINES = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [NUM_LINES-1:0] irq_lines_i,  // Asynchronous pins
    ipic_ctrl_if.detect          ctrl,
    output logic [NUM_LINES-1:0] lvl_o,        // Active level after inversion
    output logic [NUM_LINES-1:0] edge_o        // One cycle per active transition
);

    logic [NUM_LINES-1:0] sync_q1;   // First stage, may be metastable
    logic [NUM_LINES-1:0] sync_q2;   // Safe to use
    logic [NUM_LINES-1:0] prev_q;    // Synchronized value one cycle back

    // ------------------------------
    // Synchronizer and history
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
            prev_q  <= '0;
        end else begin
            sync_q1 <= irq_lines_i;
            sync_q2 <= sync_q1;
            prev_q  <= sync_q2;
        end
    end

    // Inverted lines are active low
    assign lvl_o = sync_q2 ^ ctrl.iinvr;

    // Any change that lands on the active level counts,
    // so an inverted line fires on its falling edge
    assign edge_o = (sync_q2 ^ prev_q) & lvl_o;

endmodule

//--- src/ipic_prio_find.sv
// Fixed-priority search that returns the lowest set bit index of a vector
`timescale 1ns/1ns

module ipic_prio_find #(
    parameter int WIDTH = 16
) (
    input  logic [WIDTH-1:0]         vec_i,
    output logic                     found_o,
    output logic [$clog2(WIDTH)-1:0] idx_o
);

    localparam int LVLS = $clog2(WIDTH);

    logic [WIDTH-1:0] vd [LVLS+1];           // Node valid per tree level
    logic [LVLS-1:0]  ix [LVLS+1][WIDTH];    // Partial index per node

    // Pairwise reduction, left (lower) child wins
    always_comb begin
        for (int l = 0; l <= LVLS; l++) begin
            vd[l] = '0;
            for (int n = 0; n < WIDTH; n++) ix[l][n] = '0;
        end
        vd[0] = vec_i;
        for (int l = 0; l < LVLS; l++) begin
            for (int n = 0; n < (WIDTH >> (l + 1)); n++) begin
                vd[l+1][n] = vd[l][2*n] | vd[l][2*n+1];
                if (vd[l][2*n]) begin
                    ix[l+1][n] = ix[l][2*n];
                end else begin
                    ix[l+1][n]    = ix[l][2*n+1];
                    ix[l+1][n][l] = 1'b1;    // Right half adds this level's weight
                end
            end
        end
    end

    assign found_o = vd[LVLS][0];
    assign idx_o   = ix[LVLS][0];

endmodule

//--- src/ipic_ctrl_if.sv
// Control bundle between register block, pending logic, service logic and line front end
`timescale 1ns/1ns

interface ipic_ctrl_if import ipic_pkg::*; #(
    parameter int NUM_LINES = 16
) ();
    localparam int IDX_W = $clog2(NUM_LINES);

    // Write strobes, already qualified by request and address
    logic                 icsr_wr;
    logic                 ipr_wr;
    logic                 soi_wr;
    logic                 eoi_wr;
    csr_data_t            wdata;      // Raw write data

    // Configuration from the register block
    logic [IDX_W-1:0]     idx;
    logic [NUM_LINES-1:0] ier;
    logic [NUM_LINES-1:0] imr;
    logic [NUM_LINES-1:0] iinvr;

    // State owned by pending and service logic
    logic [NUM_LINES-1:0] ipr;
    logic [NUM_LINES-1:0] isvr;
    logic                 start;      // Accepted SOI, one cycle
    logic [IDX_W-1:0]     start_idx;  // Line being started

    modport regs    (output icsr_wr, ipr_wr, soi_wr, eoi_wr, wdata, idx, ier, imr, iinvr,
                     input  ipr, isvr);
    modport pending (input  icsr_wr, ipr_wr, wdata, idx, imr, start, start_idx, output ipr);
    modport service (input  soi_wr, eoi_wr, ipr, ier, output isvr, start, start_idx);
    modport detect  (input  iinvr);
endinterface

//--- src/ipic_pkg.sv
// Shared constants and CSR types for the interrupt controller
package ipic_pkg;

    // ------------------------------
    // Geometry and bus widths
    // ------------------------------
    localparam int IPIC_LINES = 16;          // Default line count, power of two
    localparam int CSR_XLEN   = 32;          // CSR data width
    localparam int CSR_AW     = 3;           // One word per register

    typedef logic [CSR_XLEN-1:0] csr_data_t; // CSR read and write data
    typedef logic [CSR_AW-1:0]   csr_addr_t; // Register address
    typedef logic [1:0]          prv_t;      // Privilege field

    // ------------------------------
    // Address map
    // ------------------------------
    localparam csr_addr_t ADDR_CISV  = 3'd0; // Current vector in service
    localparam csr_addr_t ADDR_CICSR = 3'd1; // Reserved, reads zero
    localparam csr_addr_t ADDR_IPR   = 3'd2; // Pending, write 1 clears
    localparam csr_addr_t ADDR_ISVR  = 3'd3; // In service, read only
    localparam csr_addr_t ADDR_EOI   = 3'd4; // End of interrupt
    localparam csr_addr_t ADDR_SOI   = 3'd5; // Start of interrupt
    localparam csr_addr_t ADDR_IDX   = 3'd6; // Line select for ICSR
    localparam csr_addr_t ADDR_ICSR  = 3'd7; // Per-line control window

    // ICSR layout
    localparam int ICSR_IP     = 0;          // Pending
    localparam int ICSR_IE     = 1;          // Enable
    localparam int ICSR_IM     = 2;          // 1 edge, 0 level
    localparam int ICSR_INV    = 3;          // Line inversion
    localparam int ICSR_IS     = 4;          // In service
    localparam int ICSR_PRV_LSB = 8;
    localparam int ICSR_LN_LSB  = 12;
    localparam int ICSR_LN_W    = 4;         // Line number field width
    localparam prv_t PRV_M      = 2'd3;      // Machine level only

endpackage
